// ==== harvard_cache.f ====
cache_pkg.sv
mem_bus_if.sv
icache.sv
dcache.sv
mem_arbiter.sv
harvard_cache.sv
harvard_cache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = harvard_cache_tb
FILELIST  = harvard_cache.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== harvard_cache_tb.sv ====
/*
 * Harvard cache front end testbench
 * Table of fetch, data read and data write tests against a memory model
 * with random response delay, burst order and hit checks
 */
`timescale 1ns/10ps

module harvard_cache_tb;

    typedef enum logic [1:0] {
        p_fetch,
        p_dread,
        p_dwrite
    } port_t;

    // Expected memory traffic of a test
    typedef enum logic [1:0] {
        h_any,
        h_yes,
        h_no
    } hit_t;

    logic                  clk;
    logic                  reset;
    cache_pkg::word_addr_t i_addr;
    logic                  i_access;
    cache_pkg::word_t      i_data;
    logic                  i_ack;
    cache_pkg::word_addr_t d_addr;
    cache_pkg::word_t      d_wdata;
    logic                  d_write;
    logic                  d_access;
    cache_pkg::word_t      d_rdata;
    logic                  d_ack;
    cache_pkg::word_addr_t m_addr;
    cache_pkg::word_t      m_wdata;
    logic                  m_write;
    logic                  m_access;
    cache_pkg::word_t      m_rdata;
    logic                  m_ack;

    // Stimulus table, one element per test in each queue
    string                 t_name[$];
    port_t                 t_port[$];
    cache_pkg::word_addr_t t_addr[$];
    cache_pkg::word_addr_t t_daddr[$];
    cache_pkg::word_t      t_wdata[$];
    logic                  t_dual[$];
    hit_t                  t_hit[$];
    logic                  table_ready;

    // Every request the memory model answered, in order
    cache_pkg::word_addr_t req_addr[$];
    logic                  req_write[$];
    cache_pkg::word_t      req_wdata[$];

    cache_pkg::word_t      mem [4096];
    int                    errors;

    harvard_cache uut (
        .clk      (clk),
        .reset    (reset),
        .i_addr   (i_addr),
        .i_access (i_access),
        .i_data   (i_data),
        .i_ack    (i_ack),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_write  (d_write),
        .d_access (d_access),
        .d_rdata  (d_rdata),
        .d_ack    (d_ack),
        .m_addr   (m_addr),
        .m_wdata  (m_wdata),
        .m_write  (m_write),
        .m_access (m_access),
        .m_rdata  (m_rdata),
        .m_ack    (m_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Power-up memory contents, later table writes override
    function automatic cache_pkg::word_t expected_word(input int k,
                                                       input cache_pkg::word_addr_t addr);
        cache_pkg::word_t w;
        int               j;
        w = 16'(addr) ^ 16'h5a00;
        for (j = 0; j < k; j++)
            if (t_port[j] == p_dwrite && t_addr[j] == addr)
                w = t_wdata[j];
        return w;
    endfunction

    task automatic add_test(input string name, input port_t port,
                            input cache_pkg::word_addr_t addr,
                            input cache_pkg::word_addr_t daddr,
                            input cache_pkg::word_t wdata, input logic dual, input hit_t hit);
        t_name.push_back(name);
        t_port.push_back(port);
        t_addr.push_back(addr);
        t_daddr.push_back(daddr);
        t_wdata.push_back(wdata);
        t_dual.push_back(dual);
        t_hit.push_back(hit);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expv, input logic [31:0] gotv);
        assert (gotv == expv) else begin
            errors++;
            $display("Error %s: %s expected %h, actual %h", name, what, expv, gotv);
        end
    endtask

    task automatic check_true(input logic cond, input string name, input string text);
        assert (cond) else begin
            errors++;
            $display("%s: %s", name, text);
        end
    endtask

    // Index bits 9:4, tag from bit 10 up; addresses stay inside the model
    task automatic build_table();
        add_test("fetch_miss",       p_fetch,  19'h00123, 19'h0,     16'h0000, 1'b0, h_no);
        add_test("fetch_hit",        p_fetch,  19'h00127, 19'h0,     16'h0000, 1'b0, h_yes);
        add_test("dread_miss",       p_dread,  19'h00240, 19'h0,     16'h0000, 1'b0, h_no);
        add_test("dread_hit",        p_dread,  19'h00247, 19'h0,     16'h0000, 1'b0, h_yes);
        add_test("dwrite_hit",       p_dwrite, 19'h00243, 19'h0,     16'hbeef, 1'b0, h_any);
        add_test("dread_wr_hit",     p_dread,  19'h00243, 19'h0,     16'h0000, 1'b0, h_yes);
        add_test("dwrite_miss",      p_dwrite, 19'h00351, 19'h0,     16'h1234, 1'b0, h_any);
        add_test("dread_wr_miss",    p_dread,  19'h00351, 19'h0,     16'h0000, 1'b0, h_no);
        add_test("fetch_and_dread",  p_fetch,  19'h00400, 19'h00588, 16'h0000, 1'b1, h_no);
        add_test("alias_a",          p_dread,  19'h00064, 19'h0,     16'h0000, 1'b0, h_no);
        add_test("alias_b",          p_dread,  19'h00464, 19'h0,     16'h0000, 1'b0, h_no);
        add_test("alias_a_again",    p_dread,  19'h00064, 19'h0,     16'h0000, 1'b0, h_no);
        add_test("alias_b_again",    p_dread,  19'h00467, 19'h0,     16'h0000, 1'b0, h_no);
    endtask

    // One table entry, fetch and data side run until both have seen ack
    task automatic apply_entry(input int k);
        int                    cycles;
        int                    first_req;
        int                    n_req;
        int                    fill_words;
        logic                  i_busy;
        logic                  d_busy;
        cache_pkg::word_t      i_got;
        cache_pkg::word_t      d_got;
        cache_pkg::word_addr_t d_target;
        cache_pkg::word_addr_t first_addr;
        i_busy     = (t_port[k] == p_fetch);
        d_busy     = (t_port[k] != p_fetch) || t_dual[k];
        d_target   = t_dual[k] ? t_daddr[k] : t_addr[k];
        first_req  = req_addr.size();
        cycles     = 0;
        i_got      = '0;
        d_got      = '0;
        fill_words = t_dual[k] ? 16 : 8;
        @(posedge clk);
        #1;
        i_addr   = t_addr[k];
        i_access = i_busy;
        d_addr   = d_target;
        d_wdata  = t_wdata[k];
        d_write  = (t_port[k] == p_dwrite);
        d_access = d_busy;
        while (i_busy || d_busy) begin
            @(posedge clk);
            #1;
            cycles++;
            if (i_busy && i_ack) begin
                i_got    = i_data;
                i_access = 1'b0;
                i_busy   = 1'b0;
            end
            if (d_busy && d_ack) begin
                d_got    = d_rdata;
                d_access = 1'b0;
                d_write  = 1'b0;
                d_busy   = 1'b0;
            end
        end
        n_req = req_addr.size() - first_req;
        if (t_port[k] == p_fetch)
            check_value(t_name[k], "fetch data", 32'(expected_word(k, t_addr[k])), 32'(i_got));
        if (t_port[k] == p_dread || t_dual[k])
            check_value(t_name[k], "read data", 32'(expected_word(k, d_target)), 32'(d_got));
        if (t_port[k] == p_dwrite) begin
            check_true(n_req == 1, t_name[k],
                       $sformatf("expected one memory write, saw %0d requests", n_req));
            if (n_req > 0) begin
                first_addr = req_addr[first_req];
                check_true(req_write[first_req], t_name[k], "data write reached memory as a read");
                check_value(t_name[k], "write address", 32'(t_addr[k]), 32'(first_addr));
                check_value(t_name[k], "write data", 32'(t_wdata[k]),
                            32'(req_wdata[first_req]));
            end
        end else if (t_hit[k] == h_yes) begin
            check_true(n_req == 0 && cycles == 2, t_name[k],
                       $sformatf("expected a hit, saw %0d memory requests, ack after %0d cycles",
                                 n_req, cycles));
        end else if (t_hit[k] == h_no) begin
            check_true(n_req == fill_words, t_name[k],
                       $sformatf("expected %0d fill words, saw %0d", fill_words, n_req));
            if (n_req > 0 && !t_dual[k]) begin
                first_addr = req_addr[first_req];
                check_true(first_addr[19:4] == t_addr[k][19:4], t_name[k],
                           "fill burst fetched a different line");
            end
        end
    endtask

    // Memory model, answers one request at a time after 1 to 4 cycles
    initial begin : memory_model
        logic [31:0]        lfsr;
        logic [1:0]         delay;
        logic               pending;
        cache_pkg::offset_t burst_pos;
        logic [15:0]        burst_line;
        int                 a;
        lfsr       = 32'h13cc_6591;
        delay      = 2'd0;
        pending    = 1'b0;
        burst_pos  = '0;
        burst_line = '0;
        m_ack      = 1'b0;
        m_rdata    = '0;
        for (a = 0; a < 4096; a++)
            mem[12'(a)] = 16'(a) ^ 16'h5a00;
        forever begin
            @(posedge clk);
            #1;
            m_ack = 1'b0;
            if (m_access && !pending) begin
                pending = 1'b1;
                // Two LFSR bits make the extra wait
                repeat (2) begin
                    delay = {delay[0], lfsr[0]};
                    lfsr  = lfsr_step(lfsr);
                end
            end
            if (pending && delay != 2'd0) begin
                delay = delay - 2'd1;
            end else if (pending) begin
                pending = 1'b0;
                check_true(m_addr[19:13] == '0, "memory", "request outside the memory model");
                req_addr.push_back(m_addr);
                req_write.push_back(m_write);
                req_wdata.push_back(m_wdata);
                if (m_write) begin
                    check_true(burst_pos == 3'd0, "memory", "write arrived inside a fill burst");
                    mem[m_addr[12:1]] = m_wdata;
                end else begin
                    // A burst walks offsets 0 to 7 of one line with nothing in between
                    if (burst_pos == 3'd0) begin
                        check_true(m_addr[3:1] == 3'd0, "memory",
                                   "fill burst did not start at line offset 0");
                        burst_line = m_addr[19:4];
                    end else begin
                        check_true(m_addr[19:4] == burst_line && m_addr[3:1] == burst_pos,
                                   "memory", "fill burst out of order or mixed with another line");
                    end
                    burst_pos = burst_pos + 3'd1;
                    m_rdata   = mem[m_addr[12:1]];
                end
                m_ack = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (table_ready);
        repeat (t_name.size() * 200) @(posedge clk);
        $display("Timeout after %0d cycles, a request never finished", t_name.size() * 200);
        $display("Errors: %0d", errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main
        int k;
        errors      = 0;
        table_ready = 1'b0;
        reset       = 1'b1;
        i_addr      = '0;
        i_access    = 1'b0;
        d_addr      = '0;
        d_wdata     = '0;
        d_write     = 1'b0;
        d_access    = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        // Quiet outputs with no request after reset
        repeat (5) begin
            @(posedge clk);
            #1;
            check_true(!i_ack && !d_ack && !m_access, "idle",
                       "ack or memory access raised with no request pending");
        end
        for (k = 0; k < t_name.size(); k++)
            apply_entry(k);
        repeat (2) @(posedge clk);
        $display("Tests: %0d, errors: %0d", t_name.size(), errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== harvard_cache.sv ====
/*
 * Harvard cache front end
 * Instruction and data caches side by side, sharing one external
 * memory port through the arbiter
 */
`timescale 1ns/10ps

module harvard_cache (
    input  logic                  clk,
    input  logic                  reset,
    // Fetch port
    input  cache_pkg::word_addr_t i_addr,
    input  logic                  i_access,
    output cache_pkg::word_t      i_data,
    output logic                  i_ack,
    // Data port
    input  cache_pkg::word_addr_t d_addr,
    input  cache_pkg::word_t      d_wdata,
    input  logic                  d_write,
    input  logic                  d_access,
    output cache_pkg::word_t      d_rdata,
    output logic                  d_ack,
    // External memory
    output cache_pkg::word_addr_t m_addr,
    output cache_pkg::word_t      m_wdata,
    output logic                  m_write,
    output logic                  m_access,
    input  cache_pkg::word_t      m_rdata,
    input  logic                  m_ack
);

    // Per-cache request buses into the arbiter
    mem_bus_if i_bus ();
    mem_bus_if d_bus ();

    icache u_icache (
        .clk    (clk),
        .reset  (reset),
        .addr   (i_addr),
        .access (i_access),
        .data   (i_data),
        .ack    (i_ack),
        .mem    (i_bus)
    );

    dcache u_dcache (
        .clk    (clk),
        .reset  (reset),
        .addr   (d_addr),
        .wdata  (d_wdata),
        .write  (d_write),
        .access (d_access),
        .rdata  (d_rdata),
        .ack    (d_ack),
        .mem    (d_bus)
    );

    mem_arbiter u_arbiter (
        .clk      (clk),
        .reset    (reset),
        .inst     (i_bus),
        .data     (d_bus),
        .m_addr   (m_addr),
        .m_wdata  (m_wdata),
        .m_write  (m_write),
        .m_access (m_access),
        .m_rdata  (m_rdata),
        .m_ack    (m_ack)
    );

endmodule

// ==== mem_arbiter.sv ====
/*
 * Memory arbiter
 * Round robin between the instruction and data caches; the winner keeps
 * the external port for its whole burst or write
 */
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    mem_bus_if.arbiter            inst,
    mem_bus_if.arbiter            data,
    output cache_pkg::word_addr_t m_addr,
    output cache_pkg::word_t      m_wdata,
    output logic                  m_write,
    output logic                  m_access,
    input  cache_pkg::word_t      m_rdata,
    input  logic                  m_ack
);

    cache_pkg::client_t owner;
    // High when the data cache had the last grant
    logic               last_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owner     <= cache_pkg::client_none;
            last_data <= 1'b0;
        end else begin
            case (owner)
                cache_pkg::client_none: begin
                    // On a tie the side not served last wins
                    if (inst.access && (!data.access || last_data)) begin
                        owner     <= cache_pkg::client_inst;
                        last_data <= 1'b0;
                    end else if (data.access) begin
                        owner     <= cache_pkg::client_data;
                        last_data <= 1'b1;
                    end
                end
                cache_pkg::client_inst: if (!inst.access) owner <= cache_pkg::client_none;
                cache_pkg::client_data: if (!data.access) owner <= cache_pkg::client_none;
                default: owner <= cache_pkg::client_none;
            endcase
        end
    end

    // Request and response paths are pure muxes, no added cycle
    always_comb begin
        m_addr     = '0;
        m_wdata    = '0;
        m_write    = 1'b0;
        m_access   = 1'b0;
        inst.rdata = '0;
        inst.ack   = 1'b0;
        data.rdata = '0;
        data.ack   = 1'b0;
        case (owner)
            cache_pkg::client_inst: begin
                m_addr     = inst.addr;
                m_wdata    = inst.wdata;
                m_write    = inst.write;
                m_access   = inst.access;
                inst.rdata = m_rdata;
                inst.ack   = m_ack;
            end
            cache_pkg::client_data: begin
                m_addr     = data.addr;
                m_wdata    = data.wdata;
                m_write    = data.write;
                m_access   = data.access;
                data.rdata = m_rdata;
                data.ack   = m_ack;
            end
            default: ;
        endcase
    end

    // Each memory ack lands on exactly one cache, the owner
    a_ack_to_owner: assert property (@(posedge clk) disable iff (reset)
        m_ack |-> owner != cache_pkg::client_none && (inst.ack != data.ack));

endmodule

// ==== dcache.sv ====
/*
 * Data cache
 * Direct mapped with 8-word line fill on a read miss; word writes go
 * straight through to memory and update the cached copy on a hit only
 */
`timescale 1ns/10ps

module dcache (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::word_addr_t addr,
    input  cache_pkg::word_t      wdata,
    input  logic                  write,
    input  logic                  access,
    output cache_pkg::word_t      rdata,
    output logic                  ack,
    mem_bus_if.cache              mem
);

    typedef enum logic [1:0] {
        dc_idle,
        dc_lookup,
        dc_fill,
        dc_write
    } dc_state_t;

    dc_state_t state;

    // Storage, one tag and valid bit per line
    cache_pkg::tag_t                 tag_ram [cache_pkg::num_lines];
    cache_pkg::word_t                data_ram [cache_pkg::num_lines * cache_pkg::line_words];
    logic [cache_pkg::num_lines-1:0] valid;

    // Fields of the request address
    cache_pkg::tag_t    req_tag;
    cache_pkg::index_t  req_index;
    cache_pkg::offset_t req_offset;

    // Array outputs, one cycle behind the address
    cache_pkg::tag_t  tag_q;
    logic             valid_q;
    cache_pkg::word_t data_q;
    logic             hit;

    // Line under fill
    cache_pkg::tag_t    fill_tag;
    cache_pkg::index_t  fill_index;
    cache_pkg::offset_t fill_offset;
    logic               fill_last;

    assign {req_tag, req_index, req_offset} = addr;

    assign hit       = valid_q && (tag_q == req_tag);
    assign fill_last = (fill_offset == '1);

    // Write passes the CPU word through, fill walks the latched line
    assign mem.addr   = (state == dc_write) ? addr : {fill_tag, fill_index, fill_offset};
    assign mem.wdata  = wdata;
    assign mem.write  = (state == dc_write);
    assign mem.access = (state == dc_fill) || (state == dc_write);

    assign rdata = data_q;

    always_ff @(posedge clk) begin
        tag_q   <= tag_ram[req_index];
        valid_q <= valid[req_index];
        data_q  <= data_ram[{req_index, req_offset}];
        if (state == dc_lookup) begin
            fill_tag   <= req_tag;
            fill_index <= req_index;
        end
        if (state == dc_fill && mem.ack) begin
            data_ram[{fill_index, fill_offset}] <= mem.rdata;
            if (fill_last)
                tag_ram[fill_index] <= fill_tag;
        end
        // Write hit keeps the cached word in step with memory
        // tag_q is settled by now since memory never acks in the first write cycle
        if (state == dc_write && mem.ack && hit)
            data_ram[{req_index, req_offset}] <= wdata;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= dc_idle;
            ack         <= 1'b0;
            valid       <= '0;
            fill_offset <= '0;
        end else begin
            ack <= 1'b0;
            case (state)
                dc_idle: begin
                    // Ignore the access still high in the cycle after an ack
                    if (access && !ack)
                        state <= write ? dc_write : dc_lookup;
                end
                dc_lookup: begin
                    if (hit) begin
                        ack   <= 1'b1;
                        state <= dc_idle;
                    end else begin
                        valid[req_index] <= 1'b0;
                        fill_offset      <= '0;
                        state            <= dc_fill;
                    end
                end
                dc_fill: begin
                    if (mem.ack) begin
                        fill_offset <= fill_offset + 1'b1;
                        if (fill_last) begin
                            valid[fill_index] <= 1'b1;
                            state             <= dc_idle;
                        end
                    end
                end
                dc_write: begin
                    // Miss does not allocate, only memory sees the word
                    if (mem.ack) begin
                        ack   <= 1'b1;
                        state <= dc_idle;
                    end
                end
                default: state <= dc_idle;
            endcase
        end
    end

    // Write request stays put until memory takes it
    a_write_held: assert property (@(posedge clk) disable iff (reset)
        state == dc_write && !mem.ack |=> mem.write && $stable(mem.addr));

endmodule

// ==== icache.sv ====
/*
 * Instruction cache
 * Direct mapped and read only; a miss fills the whole 8-word line
 * through the memory bus and the fetch then hits on the new line
 */
`timescale 1ns/10ps

module icache (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::word_addr_t addr,
    input  logic                  access,
    output cache_pkg::word_t      data,
    output logic                  ack,
    mem_bus_if.cache              mem
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_fill
    } fill_state_t;

    fill_state_t state;

    // Storage, one tag and valid bit per line
    cache_pkg::tag_t                 tag_ram [cache_pkg::num_lines];
    cache_pkg::word_t                data_ram [cache_pkg::num_lines * cache_pkg::line_words];
    logic [cache_pkg::num_lines-1:0] valid;

    // Fields of the fetch address
    cache_pkg::tag_t    req_tag;
    cache_pkg::index_t  req_index;
    cache_pkg::offset_t req_offset;

    // Array outputs, one cycle behind the address
    cache_pkg::tag_t  tag_q;
    logic             valid_q;
    cache_pkg::word_t data_q;
    logic             hit;

    // Line under fill
    cache_pkg::tag_t    fill_tag;
    cache_pkg::index_t  fill_index;
    cache_pkg::offset_t fill_offset;
    logic               fill_last;

    assign {req_tag, req_index, req_offset} = addr;

    assign hit       = valid_q && (tag_q == req_tag);
    assign fill_last = (fill_offset == '1);

    // Burst always starts at offset 0 of the latched line
    assign mem.addr   = {fill_tag, fill_index, fill_offset};
    assign mem.access = (state == st_fill);
    assign mem.write  = 1'b0;
    assign mem.wdata  = '0;

    assign data = data_q;

    // Array read every cycle at the held fetch address
    always_ff @(posedge clk) begin
        tag_q   <= tag_ram[req_index];
        valid_q <= valid[req_index];
        data_q  <= data_ram[{req_index, req_offset}];
        if (state == st_lookup) begin
            fill_tag   <= req_tag;
            fill_index <= req_index;
        end
        if (state == st_fill && mem.ack) begin
            data_ram[{fill_index, fill_offset}] <= mem.rdata;
            if (fill_last)
                tag_ram[fill_index] <= fill_tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= st_idle;
            ack         <= 1'b0;
            valid       <= '0;
            fill_offset <= '0;
        end else begin
            ack <= 1'b0;
            case (state)
                // Skip the cycle right after an ack, access is still up then
                st_idle: if (access && !ack) state <= st_lookup;
                st_lookup: begin
                    if (hit) begin
                        ack   <= 1'b1;
                        state <= st_idle;
                    end else begin
                        valid[req_index] <= 1'b0;
                        fill_offset      <= '0;
                        state            <= st_fill;
                    end
                end
                st_fill: begin
                    if (mem.ack) begin
                        fill_offset <= fill_offset + 1'b1;
                        // Through idle so the arrays are read again before lookup
                        if (fill_last) begin
                            valid[fill_index] <= 1'b1;
                            state             <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // No fetch answer while the line is still arriving
    a_no_ack_in_fill: assert property (@(posedge clk) disable iff (reset)
        state == st_fill |-> !ack);

    // Instruction side never writes memory
    a_read_only: assert property (@(posedge clk) disable iff (reset)
        mem.access |-> !mem.write);

endmodule

// ==== mem_bus_if.sv ====
/*
 * Cache to arbiter memory request bus
 * One word per ack, bursts keep access high and step the address
 */
`timescale 1ns/10ps

interface mem_bus_if;

    // Request side, held stable until ack
    cache_pkg::word_addr_t addr;
    cache_pkg::word_t      wdata;
    logic                  write;
    logic                  access;

    // Response side, one ack pulse per word
    cache_pkg::word_t      rdata;
    logic                  ack;

    modport cache (output addr, wdata, write, access, input rdata, ack);

    modport arbiter (input addr, wdata, write, access, output rdata, ack);

endinterface

// ==== cache_pkg.sv ====
/*
 * Cache front end package
 * Address and data word types, line geometry and arbiter owner encoding
 * shared by both caches, the memory arbiter and the top level
 */
package cache_pkg;

    // Line geometry
    localparam int num_lines   = 64;
    localparam int line_words  = 8;
    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits  = $clog2(num_lines);
    // What is left of the 19-bit word address
    localparam int tag_bits    = 19 - index_bits - offset_bits;

    // Word address, bits 19 down to 1 of the byte address
    typedef logic [19:1] word_addr_t;
    typedef logic [15:0] word_t;

    // Address fields, tag above index above offset
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [offset_bits-1:0] offset_t;

    // Current owner of the external memory port
    typedef enum logic [1:0] {
        client_none,
        client_inst,
        client_data
    } client_t;

endpackage
